/* src/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Datapath widths
`define UART_DIV_W     16
`define UART_DATA_W    8
`define UART_CFG_W     16

// Values loaded on reset, 8N1 at divider 3
`define UART_RESET_DIV  16'd3
`define UART_RESET_EN   1'b1
`define UART_RESET_PAR  1'b0
`define UART_RESET_BITS 2'd3

// CFG_CTRL field positions in the write data
`define UART_CTRL_EN_BIT   0
`define UART_CTRL_PAR_BIT  1
`define UART_CTRL_BITS_LSB 2

`endif

/* src/uart_pkg.sv */
package uart_pkg;

  // Register map
  typedef enum logic [1:0] {
    CFG_DIV     = 2'd0,  // Bit-period divider
    CFG_CTRL    = 2'd1,  // Enable, parity enable, bits code
    CFG_CLR_ERR = 2'd2   // Any write clears the sticky error
  } cfg_addr_e;

  // Transmitter FSM
  typedef enum logic [2:0] {
    TX_IDLE   = 3'd0,
    TX_START  = 3'd1,
    TX_DATA   = 3'd2,
    TX_PARITY = 3'd3,
    TX_STOP   = 3'd4
  } tx_state_e;

  // Receiver FSM
  typedef enum logic [2:0] {
    RX_IDLE   = 3'd0,
    RX_START  = 3'd1,
    RX_DATA   = 3'd2,
    RX_PARITY = 3'd3,
    RX_STOP   = 3'd4
  } rx_state_e;

endpackage

/* src/uart_cfg_regs.sv */
`include "uart_defines.svh"

module uart_cfg_regs (
  input  logic                   rx_valid,
  input  logic                   rst_n_i,
  input  logic                   cfg_we_i,
  input  uart_pkg::cfg_addr_e    cfg_addr_i,
  input  logic [`UART_CFG_W-1:0] cfg_wdata_i,
  input  logic                   rx_perr_i,
  output logic                   cfg_en_o,
  output logic [`UART_DIV_W-1:0] cfg_div_o,
  output logic                   cfg_parity_en_o,
  output logic [1:0]             cfg_bits_o,
  output logic                   parity_err_o
);

  import uart_pkg::*;

  logic clr_err;

  assign clr_err = cfg_we_i && (cfg_addr_i == CFG_CLR_ERR);

  // ##################################################################
  // Configuration registers
  // ##################################################################

  always_ff @(posedge rx_valid)
  begin
    if (!rst_n_i)
    begin
      cfg_div_o       <= `UART_RESET_DIV;
      cfg_en_o        <= `UART_RESET_EN;
      cfg_parity_en_o <= `UART_RESET_PAR;
      cfg_bits_o      <= `UART_RESET_BITS;
    end
    else if (cfg_we_i)
    begin
      case (cfg_addr_i)
        CFG_DIV:
          cfg_div_o <= cfg_wdata_i[`UART_DIV_W-1:0];
        CFG_CTRL:
        begin
          cfg_en_o        <= cfg_wdata_i[`UART_CTRL_EN_BIT];
          cfg_parity_en_o <= cfg_wdata_i[`UART_CTRL_PAR_BIT];
          cfg_bits_o      <= cfg_wdata_i[`UART_CTRL_BITS_LSB +: 2];  // Width is 5 + code
        end
        default: ;  // CFG_CLR_ERR handled below
      endcase
    end
  end

  // ##################################################################
  // Sticky parity error
  // ##################################################################

  always_ff @(posedge rx_valid)
  begin
    if (!rst_n_i)
      parity_err_o <= 1'b0;
    else if (rx_perr_i)
      parity_err_o <= 1'b1;  // Set wins over a clear in the same cycle
    else if (clr_err)
      parity_err_o <= 1'b0;
  end

endmodule

/* src/uart_tx.sv */
`include "uart_defines.svh"

module uart_tx (
  input  logic                    rx_valid,
  input  logic                    rst_n_i,
  input  logic                    cfg_en_i,
  input  logic [`UART_DIV_W-1:0]  cfg_div_i,
  input  logic                    cfg_parity_en_i,
  input  logic [1:0]              cfg_bits_i,
  input  logic                    tx_start_i,
  input  logic [`UART_DATA_W-1:0] tx_data_i,
  output logic                    uart_tx_o,
  output logic                    tx_busy_o
);

  import uart_pkg::*;

  tx_state_e               tx_state;
  logic [`UART_DIV_W-1:0]  baud_cnt;
  logic [`UART_DIV_W-1:0]  div_q;
  logic                    parity_en_q;
  logic [1:0]              bits_q;
  logic [2:0]              bit_cnt;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    parity_q;
  logic                    bit_done;
  logic                    last_bit;
  logic                    accept;

  assign accept    = tx_start_i && cfg_en_i && !tx_busy_o;
  assign bit_done  = (baud_cnt == div_q);
  assign last_bit  = (bit_cnt == (3'd4 + {1'b0, bits_q}));  // Index of the top data bit
  assign tx_busy_o = (tx_state != TX_IDLE);

  // Frame settings and data, captured on acceptance
  always_ff @(posedge rx_valid)
  begin
    if (accept)
    begin
      div_q       <= cfg_div_i;
      parity_en_q <= cfg_parity_en_i;
      bits_q      <= cfg_bits_i;
      shift_q     <= tx_data_i;
    end
    else if (bit_done && ((tx_state == TX_START) || (tx_state == TX_DATA)))
      shift_q <= shift_q >> 1;  // Next bit moves to position 0
  end

  // ##################################################################
  // Frame FSM
  // ##################################################################

  always_ff @(posedge rx_valid)
  begin
    if (!rst_n_i)
    begin
      tx_state  <= TX_IDLE;
      uart_tx_o <= 1'b1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      parity_q  <= 1'b0;
    end
    else if (tx_state == TX_IDLE)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
      parity_q <= 1'b0;
      if (accept)
      begin
        tx_state  <= TX_START;
        uart_tx_o <= 1'b0;  // Start bit
      end
    end
    else if (!bit_done)
      baud_cnt <= baud_cnt + 1'b1;
    else
    begin
      baud_cnt <= '0;
      case (tx_state)
        TX_START:
        begin
          tx_state  <= TX_DATA;
          uart_tx_o <= shift_q[0];
          parity_q  <= shift_q[0];
        end
        TX_DATA:
        begin
          if (last_bit)
          begin
            tx_state  <= parity_en_q ? TX_PARITY : TX_STOP;
            uart_tx_o <= parity_en_q ? parity_q : 1'b1;
          end
          else
          begin
            bit_cnt   <= bit_cnt + 1'b1;
            uart_tx_o <= shift_q[0];
            parity_q  <= parity_q ^ shift_q[0];
          end
        end
        TX_PARITY:
        begin
          tx_state  <= TX_STOP;
          uart_tx_o <= 1'b1;
        end
        default:
        begin
          tx_state  <= TX_IDLE;  // End of stop bit
          uart_tx_o <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* src/uart_rx.sv */
`include "uart_defines.svh"

module uart_rx (
  input  logic                    rx_valid,
  input  logic                    rst_n_i,
  input  logic                    cfg_en_i,
  input  logic [`UART_DIV_W-1:0]  cfg_div_i,
  input  logic                    cfg_parity_en_i,
  input  logic [1:0]              cfg_bits_i,
  input  logic                    rx_i,
  output logic [`UART_DATA_W-1:0] rx_data_o,
  output logic                    rx_strobe_o,
  output logic                    rx_perr_o,
  output logic                    rx_busy_o
);

  import uart_pkg::*;

  rx_state_e               rx_state;
  logic                    rx_sync1;
  logic                    rx_sync2;
  logic                    rx_prev;
  logic [`UART_DIV_W-1:0]  baud_cnt;
  logic [`UART_DIV_W-1:0]  half_div;
  logic [2:0]              bit_cnt;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    parity_q;
  logic                    perr_q;
  logic                    fall_edge;
  logic                    last_bit;
  logic                    mid_bit;

  assign half_div  = cfg_div_i >> 1;
  assign fall_edge = rx_prev && !rx_sync2;
  assign last_bit  = (bit_cnt == (3'd4 + {1'b0, cfg_bits_i}));
  assign rx_busy_o = (rx_state != RX_IDLE);

  // Start bit is checked half a period in, later bits one full period apart
  assign mid_bit = (rx_state == RX_START) ? (baud_cnt == half_div)
                                          : (baud_cnt == cfg_div_i);

  // ##################################################################
  // Line synchronizer and edge detect
  // ##################################################################

  always_ff @(posedge rx_valid)
  begin
    if (!rst_n_i)
    begin
      rx_sync1 <= 1'b1;  // Idle line is high
      rx_sync2 <= 1'b1;
      rx_prev  <= 1'b1;
    end
    else
    begin
      rx_sync1 <= rx_i;
      rx_sync2 <= rx_sync1;
      rx_prev  <= rx_sync2;
    end
  end

  // ##################################################################
  // Frame FSM
  // ##################################################################

  always_ff @(posedge rx_valid)
  begin
    if (!rst_n_i)
    begin
      rx_state    <= RX_IDLE;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
      parity_q    <= 1'b0;
      perr_q      <= 1'b0;
      rx_strobe_o <= 1'b0;
      rx_perr_o   <= 1'b0;
    end
    else
    begin
      rx_strobe_o <= 1'b0;
      rx_perr_o   <= 1'b0;
      if (!cfg_en_i)
      begin
        rx_state <= RX_IDLE;
        baud_cnt <= '0;
      end
      else if (rx_state == RX_IDLE)
      begin
        baud_cnt <= '0;
        bit_cnt  <= '0;
        parity_q <= 1'b0;
        perr_q   <= 1'b0;
        if (fall_edge)
          rx_state <= RX_START;
      end
      else if (!mid_bit)
        baud_cnt <= baud_cnt + 1'b1;
      else
      begin
        baud_cnt <= '0;
        case (rx_state)
          RX_START:
            rx_state <= rx_sync2 ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
          RX_DATA:
          begin
            parity_q <= parity_q ^ rx_sync2;
            if (last_bit)
              rx_state <= cfg_parity_en_i ? RX_PARITY : RX_STOP;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          RX_PARITY:
          begin
            perr_q   <= parity_q ^ rx_sync2;  // Even parity, XOR of all must be 0
            rx_state <= RX_STOP;
          end
          default:
          begin
            rx_strobe_o <= 1'b1;
            rx_perr_o   <= perr_q;
            rx_state    <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // Data shifts in from the top, then right-aligned to the configured width
  always_ff @(posedge rx_valid)
  begin
    if (cfg_en_i && mid_bit && (rx_state == RX_DATA))
      shift_q <= {rx_sync2, shift_q[`UART_DATA_W-1:1]};
    if (cfg_en_i && mid_bit && (rx_state == RX_STOP))
      rx_data_o <= shift_q >> (2'd3 - cfg_bits_i);
  end

endmodule

/* src/uart_link_top.sv */
`include "uart_defines.svh"

module uart_link_top (
  input  logic                    rx_valid,
  input  logic                    rst_n_i,
  input  logic                    cfg_we_i,
  input  uart_pkg::cfg_addr_e     cfg_addr_i,
  input  logic [`UART_CFG_W-1:0]  cfg_wdata_i,
  input  logic                    tx_start_i,
  input  logic [`UART_DATA_W-1:0] tx_data_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    tx_busy_o,
  output logic [`UART_DATA_W-1:0] rx_data_o,
  output logic                    rx_strobe_o,
  output logic                    rx_busy_o,
  output logic                    parity_err_o
);

  logic                   cfg_en;
  logic [`UART_DIV_W-1:0] cfg_div;
  logic                   cfg_parity_en;
  logic [1:0]             cfg_bits;
  logic                   rx_perr;  // Stays inside, feeds the sticky flag

  uart_cfg_regs i_uart_cfg_regs (
    .rx_valid        ( rx_valid      ),
    .rst_n_i         ( rst_n_i       ),
    .cfg_we_i        ( cfg_we_i      ),
    .cfg_addr_i      ( cfg_addr_i    ),
    .cfg_wdata_i     ( cfg_wdata_i   ),
    .rx_perr_i       ( rx_perr       ),
    .cfg_en_o        ( cfg_en        ),
    .cfg_div_o       ( cfg_div       ),
    .cfg_parity_en_o ( cfg_parity_en ),
    .cfg_bits_o      ( cfg_bits      ),
    .parity_err_o    ( parity_err_o  )
  );

  uart_tx i_uart_tx (
    .rx_valid        ( rx_valid      ),
    .rst_n_i         ( rst_n_i       ),
    .cfg_en_i        ( cfg_en        ),
    .cfg_div_i       ( cfg_div       ),
    .cfg_parity_en_i ( cfg_parity_en ),
    .cfg_bits_i      ( cfg_bits      ),
    .tx_start_i      ( tx_start_i    ),
    .tx_data_i       ( tx_data_i     ),
    .uart_tx_o       ( uart_tx_o     ),
    .tx_busy_o       ( tx_busy_o     )
  );

  uart_rx i_uart_rx (
    .rx_valid        ( rx_valid      ),
    .rst_n_i         ( rst_n_i       ),
    .cfg_en_i        ( cfg_en        ),
    .cfg_div_i       ( cfg_div       ),
    .cfg_parity_en_i ( cfg_parity_en ),
    .cfg_bits_i      ( cfg_bits      ),
    .rx_i            ( uart_rx_i     ),
    .rx_data_o       ( rx_data_o     ),
    .rx_strobe_o     ( rx_strobe_o   ),
    .rx_perr_o       ( rx_perr       ),
    .rx_busy_o       ( rx_busy_o     )
  );

endmodule

/* tb/uart_link_properties.sv */
module uart_link_properties (
  input logic                rx_valid,
  input logic                rst_n_i,
  input logic                cfg_we_i,
  input uart_pkg::cfg_addr_e cfg_addr_i,
  input logic                uart_tx_o,
  input logic                tx_busy_o,
  input logic                rx_strobe_o,
  input logic                parity_err_o
);

  import uart_pkg::*;

  strobe_one_cycle: assert property (@(posedge rx_valid) disable iff (!rst_n_i)
    rx_strobe_o |=> !rx_strobe_o)
    else $error("rx_strobe_o stayed high for more than one cycle");

  // Line idles high outside a frame
  line_idle_high: assert property (@(posedge rx_valid) disable iff (!rst_n_i)
    !tx_busy_o |-> uart_tx_o)
    else $error("uart_tx_o low while tx_busy_o is low");

  err_clear_only_by_write: assert property (@(posedge rx_valid) disable iff (!rst_n_i)
    $fell(parity_err_o) |-> $past(cfg_we_i && (cfg_addr_i == CFG_CLR_ERR)))
    else $error("parity_err_o fell without a CFG_CLR_ERR write");

endmodule

bind uart_link_top uart_link_properties i_uart_link_properties (
  .rx_valid     ( rx_valid     ),
  .rst_n_i      ( rst_n_i      ),
  .cfg_we_i     ( cfg_we_i     ),
  .cfg_addr_i   ( cfg_addr_i   ),
  .uart_tx_o    ( uart_tx_o    ),
  .tx_busy_o    ( tx_busy_o    ),
  .rx_strobe_o  ( rx_strobe_o  ),
  .parity_err_o ( parity_err_o )
);

/* tb/tb_uart_link.sv */
`include "uart_defines.svh"

module tb_uart_link;

  import uart_pkg::*;

  logic                    rx_valid;
  logic                    rst_n_i;
  logic                    cfg_we_i;
  cfg_addr_e               cfg_addr_i;
  logic [`UART_CFG_W-1:0]  cfg_wdata_i;
  logic                    tx_start_i;
  logic [`UART_DATA_W-1:0] tx_data_i;
  logic                    uart_rx_i;
  logic                    uart_tx_o;
  logic                    tx_busy_o;
  logic [`UART_DATA_W-1:0] rx_data_o;
  logic                    rx_strobe_o;
  logic                    rx_busy_o;
  logic                    parity_err_o;

  logic       bang_mode;  // Set to drive the line from the testbench
  logic       bang_line;
  integer     seed;
  int         err_cnt;
  int         check_cnt;
  int         test_cnt;
  int         test_err0;
  int         cycles;
  int         cycle_limit;
  int         accepted;
  int         strobe_cnt;
  int         busy_run;
  int         busy_len;
  int         cur_div;
  int         cur_bits;
  logic       cur_par;
  logic       perr_pend;
  logic [8:0] exp_item;
  logic [8:0] exp_q[$];  // {parity error, masked byte}

  assign uart_rx_i = bang_mode ? bang_line : uart_tx_o;

  uart_link_top i_uart_link_top (
    .rx_valid     ( rx_valid     ),
    .rst_n_i      ( rst_n_i      ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_addr_i   ( cfg_addr_i   ),
    .cfg_wdata_i  ( cfg_wdata_i  ),
    .tx_start_i   ( tx_start_i   ),
    .tx_data_i    ( tx_data_i    ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .tx_busy_o    ( tx_busy_o    ),
    .rx_data_o    ( rx_data_o    ),
    .rx_strobe_o  ( rx_strobe_o  ),
    .rx_busy_o    ( rx_busy_o    ),
    .parity_err_o ( parity_err_o )
  );

  always #5 rx_valid = ~rx_valid;

  // ####################################################################
  // Compare tasks and model helpers
  // ####################################################################

  task automatic check_data(input logic [`UART_DATA_W-1:0] got,
                            input logic [`UART_DATA_W-1:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error: rx_data_o = 0x%02h, expected 0x%02h", got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Frame length on tx_busy_o shows what the last write did
  task automatic check_addr_cfg(input cfg_addr_e addr, input int got, input int exp);
    check_cnt++;
    if (got != exp)
    begin
      err_cnt++;
      $display("Error: tx_busy_o length after %s write = 0x%0h, expected 0x%0h",
               addr.name(), got, exp);
    end
  endtask

  function automatic logic [7:0] width_mask(input int bits);
    return 8'((1 << (5 + bits)) - 1);
  endfunction

  function automatic logic [15:0] ctrl_word(input logic en, input logic par, input int bits);
    return {13'd0, 2'(bits), par, en};
  endfunction

  task automatic cfg_write(input cfg_addr_e addr, input logic [15:0] data);
    @(posedge rx_valid);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge rx_valid);
    cfg_we_i    <= 1'b0;
    if (addr == CFG_DIV)
      cur_div = int'(data);
    else if (addr == CFG_CTRL)
    begin
      cur_par  = data[1];
      cur_bits = int'(data[3:2]);
    end
  endtask

  task automatic wait_all();
    while (tx_busy_o || (strobe_cnt != accepted))
      @(posedge rx_valid);
  endtask

  task automatic send_byte(input logic [7:0] data);
    logic [7:0] md;
    md = data & width_mask(cur_bits);
    wait_all();
    tx_start_i <= 1'b1;
    tx_data_i  <= data;
    exp_q.push_back({1'b0, md});
    accepted++;
    cycle_limit += 22 * (cur_div + 1);
    @(posedge rx_valid);
    tx_start_i <= 1'b0;
  endtask

  // Bit-banged frame, parity bit inverted when bad is set
  task automatic bang_frame(input logic [7:0] data, input logic bad);
    logic [7:0] md;
    int         period;
    md     = data & width_mask(cur_bits);
    period = cur_div + 1;
    wait_all();
    exp_q.push_back({bad & cur_par, md});
    accepted++;
    cycle_limit += 22 * period;
    bang_line <= 1'b0;
    repeat (period) @(posedge rx_valid);
    for (int i = 0; i < 5 + cur_bits; i++)
    begin
      bang_line <= md[i];
      repeat (period) @(posedge rx_valid);
    end
    if (cur_par)
    begin
      bang_line <= (^md) ^ bad;
      repeat (period) @(posedge rx_valid);
    end
    bang_line <= 1'b1;  // Stop bit
    repeat (period) @(posedge rx_valid);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // ####################################################################
  // Monitor and timeout
  // ####################################################################

  always @(posedge rx_valid)
  begin
    if (perr_pend)
      check_flag(parity_err_o, 1'b1, "parity_err_o");
    perr_pend = 1'b0;
    if (rst_n_i && rx_strobe_o)
    begin
      if (exp_q.size() == 0)
      begin
        err_cnt++;
        $display("Receiver gave a strobe although no frame was accepted");
      end
      else
      begin
        exp_item = exp_q.pop_front();
        check_data(rx_data_o, exp_item[7:0]);
        perr_pend = exp_item[8];
      end
      strobe_cnt <= strobe_cnt + 1;
    end
    if (tx_busy_o)
      busy_run++;
    else if (busy_run != 0)
    begin
      busy_len <= busy_run;
      busy_run = 0;
    end
  end

  always @(posedge rx_valid)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial
  begin
    rx_valid    = 1'b0;
    rst_n_i     = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = CFG_DIV;
    cfg_wdata_i = '0;
    tx_start_i  = 1'b0;
    tx_data_i   = '0;
    bang_mode   = 1'b0;
    bang_line   = 1'b1;
    seed        = 32'h60063752;
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    test_err0   = 0;
    cycles      = 0;
    cycle_limit = 1000;
    accepted    = 0;
    strobe_cnt  = 0;
    busy_run    = 0;
    busy_len    = 0;
    perr_pend   = 1'b0;
    cur_div     = 3;  // Reset configuration, 8N1
    cur_bits    = 3;
    cur_par     = 1'b0;

    repeat (8) @(posedge rx_valid);
    rst_n_i <= 1'b1;
    @(posedge rx_valid);
    @(posedge rx_valid);
    check_flag(uart_tx_o, 1'b1, "uart_tx_o");
    check_flag(tx_busy_o, 1'b0, "tx_busy_o");
    check_flag(rx_strobe_o, 1'b0, "rx_strobe_o");
    check_flag(rx_busy_o, 1'b0, "rx_busy_o");
    check_flag(parity_err_o, 1'b0, "parity_err_o");
    finish_test("reset values");

    repeat (40)
      send_byte(8'($random(seed)));
    wait_all();
    check_flag(parity_err_o, 1'b0, "parity_err_o");
    finish_test("loopback at reset configuration");

    for (int b = 0; b < 4; b++)
    begin
      wait_all();
      cfg_write(CFG_DIV, 16'(1 + ({$random(seed)} % 7)));
      cfg_write(CFG_CTRL, ctrl_word(1'b1, 1'($random(seed)), int'(2'($random(seed)))));
      send_byte(8'($random(seed)));
      wait_all();
      @(posedge rx_valid);
      check_addr_cfg(CFG_CTRL, busy_len, (cur_div + 1) * (7 + cur_bits + int'(cur_par)));
      repeat (9)
        send_byte(8'($random(seed)));
    end
    wait_all();
    check_flag(parity_err_o, 1'b0, "parity_err_o");
    finish_test("random divider, width and parity");

    cfg_write(CFG_DIV, 16'd3);
    cfg_write(CFG_CTRL, ctrl_word(1'b1, 1'b1, 3));
    bang_mode <= 1'b1;
    bang_frame(8'($random(seed)), 1'b1);
    wait_all();
    @(posedge rx_valid);
    @(posedge rx_valid);
    bang_frame(8'($random(seed)), 1'b0);
    wait_all();
    @(posedge rx_valid);
    check_flag(parity_err_o, 1'b1, "parity_err_o");  // Sticky across a good frame
    cfg_write(CFG_CLR_ERR, 16'd0);
    @(posedge rx_valid);
    check_flag(parity_err_o, 1'b0, "parity_err_o");
    bang_mode <= 1'b0;
    finish_test("bad parity and sticky flag");

    for (int n = 0; n < 3; n++)
    begin
      send_byte(8'($random(seed)));
      while (!tx_busy_o)
        @(posedge rx_valid);
      tx_start_i <= 1'b1;  // Ignored, transmitter busy
      tx_data_i  <= 8'($random(seed));
      @(posedge rx_valid);
      tx_start_i <= 1'b0;
    end
    wait_all();
    cfg_write(CFG_CTRL, ctrl_word(1'b0, cur_par, cur_bits));
    @(posedge rx_valid);
    tx_start_i <= 1'b1;
    tx_data_i  <= 8'($random(seed));
    @(posedge rx_valid);
    tx_start_i <= 1'b0;
    @(posedge rx_valid);
    check_flag(tx_busy_o, 1'b0, "tx_busy_o");  // No frame while disabled
    cycle_limit += 44 * (cur_div + 1);
    repeat (22 * (cur_div + 1))
      @(posedge rx_valid);
    cfg_write(CFG_CTRL, ctrl_word(1'b1, cur_par, cur_bits));
    repeat (22 * (cur_div + 1))
      @(posedge rx_valid);
    check_cnt++;
    if (strobe_cnt != accepted)
    begin
      err_cnt++;
      $display("Error: strobe count = 0x%0h, expected 0x%0h", strobe_cnt, accepted);
    end
    finish_test("ignored starts");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* list.f */
+incdir+src
src/uart_pkg.sv
src/uart_cfg_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_link_top.sv
tb/uart_link_properties.sv
tb/tb_uart_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_uart_link \
  -o sim_uart_link > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status, see build.log"
  exit 1
fi

./obj_dir/sim_uart_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
